//--- tb_clock_gen.sv
// Testbench clock and reset source; instantiate once in the testbench top
`default_nettype none

module tb_clock_gen #(
  parameter int unsigned Period      = 40,
  parameter int unsigned ResetCycles = 5
) (
  output logic clk_o,
  output logic reset_o
);

  // Free-running clock
  initial begin
    clk_o = 1'b0;
    forever #(Period / 2) clk_o = ~clk_o;
  end

  // Reset released on a rising edge, like any other stimulus
  initial begin
    reset_o = 1'b1;
    repeat (ResetCycles) @(posedge clk_o);
    reset_o <= 1'b0;
  end

endmodule

`default_nettype wire

//--- tb_obi_checker.sv
// Bus and interrupt monitor with a reference model of the user domain; connect to the DUT ports
`default_nettype none

module tb_obi_checker import user_pkg::*; #(
  parameter int unsigned GpioCount       = 16,
  parameter int unsigned NumExternalIrqs = 4,
  parameter int unsigned ScratchDepth    = 64
) (
  input wire logic                       clk_i,
  input wire logic                       reset_i,
  input wire logic                       req_i,
  input wire logic                       gnt_i,
  input wire logic [AddrWidth-1:0]       addr_i,
  input wire logic                       we_i,
  input wire logic [DataWidth/8-1:0]     be_i,
  input wire logic [DataWidth-1:0]       wdata_i,
  input wire logic                       rvalid_i,
  input wire logic [DataWidth-1:0]       rdata_i,
  input wire logic                       err_i,
  input wire logic [GpioCount-1:0]       gpio_i,
  input wire logic [NumExternalIrqs-1:0] irq_i
);

  // Model state
  logic [DataWidth-1:0] mem_m [ScratchDepth];
  logic [GpioCount-1:0] rise_m;
  logic [GpioCount-1:0] fall_m;
  logic [GpioCount-1:0] status_m;
  logic [GpioCount-1:0] gpio_prev_m;

  // Expected response word holds the compare flag, err and data
  logic [DataWidth+1:0] exp_q [$];
  logic [AddrWidth-1:0] addr_q [$];

  int unsigned data_errors  = 0;
  int unsigned proto_errors = 0;
  int unsigned irq_errors   = 0;
  int unsigned rsp_count    = 0;

  // Everything outside the two windows is an error access
  function automatic user_target_e decode_target(input logic [AddrWidth-1:0] a);
    if (a >= ScratchBase && a < ScratchBase + ScratchSize) begin
      return UserScratch;
    end
    if (a >= GpioBase && a < GpioBase + GpioSize) begin
      return UserGpio;
    end
    return UserError;
  endfunction

  function automatic logic [DataWidth-1:0] byte_mask(input logic [DataWidth/8-1:0] b);
    logic [DataWidth-1:0] m;
    for (int i = 0; i < DataWidth / 8; i++) begin
      m[8*i +: 8] = b[i] ? 8'hFF : 8'h00;
    end
    return m;
  endfunction

  // Interrupt line k collects status bits k, k + lines, k + 2 * lines and so on
  function automatic logic [NumExternalIrqs-1:0] fold_irqs(input logic [GpioCount-1:0] st);
    logic [NumExternalIrqs-1:0] r;
    r = '0;
    for (int k = 0; k < NumExternalIrqs; k++) begin
      for (int i = k; i < GpioCount; i += NumExternalIrqs) begin
        if (st[i]) begin
          r[k] = 1'b1;
        end
      end
    end
    return r;
  endfunction

  // Pins that changed this cycle in a direction their enables allow
  function automatic logic [GpioCount-1:0] edge_hits(input logic [GpioCount-1:0] cur,
                                                     input logic [GpioCount-1:0] prev,
                                                     input logic [GpioCount-1:0] rise,
                                                     input logic [GpioCount-1:0] fall);
    logic [GpioCount-1:0] hit;
    hit = '0;
    for (int i = 0; i < GpioCount; i++) begin
      if (cur[i] != prev[i]) begin
        hit[i] = cur[i] ? rise[i] : fall[i];
      end
    end
    return hit;
  endfunction

  // --------------------------------------------------------------------------
  // Per-cycle check on the values of the cycle that just ended
  // --------------------------------------------------------------------------

  always @(posedge clk_i) begin : observe
    logic [DataWidth+1:0] exp;
    logic [AddrWidth-1:0] exp_addr;
    logic [DataWidth-1:0] rd;
    logic [DataWidth-1:0] mask;
    logic [AddrWidth-1:0] off;
    logic [GpioCount-1:0] set;
    logic [GpioCount-1:0] clr;
    logic [GpioCount-1:0] wbits;
    int unsigned          idx;
    if (reset_i) begin
      rise_m      = '0;
      fall_m      = '0;
      status_m    = '0;
      gpio_prev_m = '0;
      exp_q.delete();
      addr_q.delete();
    end else begin
      // Response due one cycle after acceptance
      if (exp_q.size() > 0) begin
        exp      = exp_q.pop_front();
        exp_addr = addr_q.pop_front();
        if (rvalid_i !== 1'b1) begin
          $display("Missing response at %0t: no rvalid_o for request to %h", $time, exp_addr);
          proto_errors++;
        end else begin
          rsp_count++;
          if (err_i !== exp[DataWidth]) begin
            $display("Error at %0t: err_o %b, expected %b, addr %h",
                     $time, err_i, exp[DataWidth], exp_addr);
            data_errors++;
          end
          if (exp[DataWidth+1] && rdata_i !== exp[DataWidth-1:0]) begin
            $display("Error at %0t: rdata_o %h, expected %h, addr %h",
                     $time, rdata_i, exp[DataWidth-1:0], exp_addr);
            data_errors++;
          end
        end
      end else if (rvalid_i !== 1'b0) begin
        $display("Extra response at %0t: rvalid_o high with no request before it", $time);
        proto_errors++;
      end
      if (rvalid_i !== 1'b1 && err_i !== 1'b0) begin
        $display("Error at %0t: err_o high outside a response", $time);
        proto_errors++;
      end

      // Interrupts follow the status of this cycle
      if (irq_i !== fold_irqs(status_m)) begin
        $display("Error at %0t: interrupts_o %b, expected %b", $time, irq_i, fold_irqs(status_m));
        irq_errors++;
      end

      // Enabled edges against the previous input
      set = edge_hits(gpio_i, gpio_prev_m, rise_m, fall_m);
      clr = '0;

      if (req_i) begin
        if (gnt_i !== 1'b1) begin
          $display("Request to %h was not granted in its own cycle at %0t", addr_i, $time);
          proto_errors++;
        end else begin
          mask  = byte_mask(be_i);
          wbits = GpioCount'(wdata_i & mask);
          rd    = '0;
          case (decode_target(addr_i))
            UserScratch: begin
              idx = (addr_i >> 2) % ScratchDepth;
              rd  = mem_m[idx];
              if (we_i) begin
                mem_m[idx] = (mem_m[idx] & ~mask) | (wdata_i & mask);
              end
              exp = {!we_i, 1'b0, rd};
            end
            UserGpio: begin
              off = addr_i - GpioBase;
              case (off)
                32'h0: rd = DataWidth'(gpio_i);
                32'h4: begin
                  rd = DataWidth'(rise_m);
                  if (we_i) rise_m = (rise_m & ~GpioCount'(mask)) | wbits;
                end
                32'h8: begin
                  rd = DataWidth'(fall_m);
                  if (we_i) fall_m = (fall_m & ~GpioCount'(mask)) | wbits;
                end
                32'hC: begin
                  rd = DataWidth'(status_m);
                  if (we_i) clr = wbits;
                end
                default: rd = '0;
              endcase
              exp = {!we_i, 1'b0, rd};
            end
            default: exp = {1'b1, 1'b1, ErrRspData};
          endcase
          exp_q.push_back(exp);
          addr_q.push_back(addr_i);
        end
      end

      // Set wins over a same-cycle clear
      status_m    = (status_m & ~clr) | set;
      gpio_prev_m = gpio_i;
    end
  end

endmodule

`default_nettype wire

//--- tb_user_domain.sv
// Testbench top for the user domain; random bus traffic and GPIO activity, run as the sim top
`default_nettype none

module tb_user_domain import user_pkg::*;;

  localparam int unsigned GpioCount       = 16;
  localparam int unsigned NumExternalIrqs = 4;
  localparam int unsigned ScratchDepth    = 64;

  // Test lengths
  localparam int unsigned ScratchOps = 200;
  localparam int unsigned ErrOps     = 40;
  localparam int unsigned PipeOps    = 60;
  localparam int unsigned GpioOps    = 300;
  localparam int unsigned NumReq     = 1 + 2 * ScratchDepth + ScratchOps + ErrOps + PipeOps
                                       + GpioOps + 4;
  localparam int unsigned NumIdle    = 3 + 2 * GpioOps + 5 + 4;
  localparam int unsigned TimeoutCycles = 4 * (NumReq + NumIdle) + 100;

  logic                       clk;
  logic                       reset;
  logic                       req;
  logic                       gnt;
  logic [AddrWidth-1:0]       addr;
  logic                       we;
  logic [DataWidth/8-1:0]     be;
  logic [DataWidth-1:0]       wdata;
  logic                       rvalid;
  logic [DataWidth-1:0]       rdata;
  logic                       err;
  logic [GpioCount-1:0]       gpio_in;
  logic [NumExternalIrqs-1:0] irqs;

  // Random pin activity on or off
  logic        wiggle;
  int unsigned n_sent;
  int unsigned cycles;

  tb_clock_gen #(.Period(40), .ResetCycles(5)) clock_i (.clk_o(clk), .reset_o(reset));

  user_domain #(
    .GpioCount       (GpioCount),
    .NumExternalIrqs (NumExternalIrqs),
    .ScratchDepth    (ScratchDepth)
  ) user_domain_i (
    .clk_i (clk), .reset_i (reset),
    .req_i (req), .gnt_o (gnt), .addr_i (addr), .we_i (we), .be_i (be), .wdata_i (wdata),
    .rvalid_o (rvalid), .rdata_o (rdata), .err_o (err),
    .gpio_in_sync_i (gpio_in), .interrupts_o (irqs)
  );

  tb_obi_checker #(
    .GpioCount       (GpioCount),
    .NumExternalIrqs (NumExternalIrqs),
    .ScratchDepth    (ScratchDepth)
  ) checker_i (
    .clk_i (clk), .reset_i (reset),
    .req_i (req), .gnt_i (gnt), .addr_i (addr), .we_i (we), .be_i (be), .wdata_i (wdata),
    .rvalid_i (rvalid), .rdata_i (rdata), .err_i (err), .gpio_i (gpio_in), .irq_i (irqs)
  );

  // --------------------------------------------------------------------------
  // Bus driver tasks, called right after a rising edge
  // --------------------------------------------------------------------------

  task automatic toggle_pins();
    if (wiggle) begin
      // Sparse flips, a few pins per cycle
      gpio_in <= gpio_in ^ GpioCount'($urandom & $urandom);
    end
  endtask

  task automatic send(input logic [AddrWidth-1:0] a, input logic w,
                      input logic [DataWidth/8-1:0] b, input logic [DataWidth-1:0] d);
    toggle_pins();
    req   <= 1'b1;
    addr  <= a;
    we    <= w;
    be    <= b;
    wdata <= d;
    n_sent++;
    @(posedge clk);
    while (gnt !== 1'b1) @(posedge clk);
  endtask

  task automatic idle(input int unsigned n);
    repeat (n) begin
      toggle_pins();
      req <= 1'b0;
      we  <= 1'b0;
      @(posedge clk);
    end
  endtask

  function automatic logic [AddrWidth-1:0] scratch_addr();
    // Whole window, so most words alias past the depth
    return ScratchBase + (($urandom % ScratchSize) & ~32'h3);
  endfunction

  function automatic logic [AddrWidth-1:0] gpio_addr();
    case ($urandom % 7)
      0:       return GpioBase + GpioIn;
      1:       return GpioBase + GpioRiseEn;
      2:       return GpioBase + GpioFallEn;
      3:       return GpioBase + GpioStatus;
      4:       return GpioBase + 32'h10;
      5:       return GpioBase + 32'h100;
      default: return GpioBase + 32'hFFC;
    endcase
  endfunction

  function automatic logic [AddrWidth-1:0] unmapped_addr();
    logic [AddrWidth-1:0] a;
    // Half above the windows in the user region, half anywhere
    if ($urandom % 2) begin
      a = UserBaseAddr + 32'h2000 + ($urandom % 32'h0100_0000);
    end else begin
      a = $urandom;
    end
    return {a[AddrWidth-1:2], 2'b00};
  endfunction

  // --------------------------------------------------------------------------
  // Timeout
  // --------------------------------------------------------------------------

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= TimeoutCycles) begin
      $display("Timeout: the run did not finish within %0d cycles", TimeoutCycles);
      $display("TB FAILED");
      $finish;
    end
  end

  // --------------------------------------------------------------------------
  // Test sequence
  // --------------------------------------------------------------------------

  initial begin
    int unsigned seed;
    int unsigned total;
    seed    = 32'hb482_a8f3;
    void'($urandom(seed));
    req     = 1'b0;
    addr    = '0;
    we      = 1'b0;
    be      = '0;
    wdata   = '0;
    gpio_in = '0;
    wiggle  = 1'b0;
    n_sent  = 0;
    cycles  = 0;

    @(posedge clk);
    while (reset) @(posedge clk);

    // Idle outputs after reset, then a clean status
    idle(3);
    send(GpioBase + GpioStatus, 1'b0, 4'hF, '0);

    // Fill every scratch word so later reads are defined
    for (int i = 0; i < ScratchDepth; i++) begin
      send(ScratchBase + 4 * i, 1'b1, 4'hF, $urandom);
    end
    for (int i = 0; i < ScratchOps; i++) begin
      send(scratch_addr(), 1'($urandom), 4'($urandom), $urandom);
    end

    // Error accesses, then a sweep showing scratch untouched
    for (int i = 0; i < ErrOps; i++) begin
      send(unmapped_addr(), 1'($urandom), 4'($urandom), $urandom);
    end
    for (int i = 0; i < ScratchDepth; i++) begin
      send(ScratchBase + 4 * i, 1'b0, 4'hF, '0);
    end

    // Alternating targets back to back
    for (int i = 0; i < PipeOps; i++) begin
      case (i % 3)
        0:       send(scratch_addr(), 1'($urandom), 4'($urandom), $urandom);
        1:       send(gpio_addr(), 1'b0, 4'hF, '0);
        default: send(unmapped_addr(), 1'b0, 4'hF, '0);
      endcase
    end

    // GPIO edges with random enables and clears
    wiggle = 1'b1;
    send(GpioBase + GpioRiseEn, 1'b1, 4'hF, $urandom);
    send(GpioBase + GpioFallEn, 1'b1, 4'hF, $urandom);
    for (int i = 0; i < GpioOps; i++) begin
      idle($urandom % 3);
      send(gpio_addr(), ($urandom % 4) == 0, 4'($urandom), $urandom);
    end
    wiggle = 1'b0;
    idle(5);

    // Clear all, status reads back zero
    send(GpioBase + GpioStatus, 1'b1, 4'hF, 32'hFFFF_FFFF);
    send(GpioBase + GpioStatus, 1'b0, 4'hF, '0);
    idle(4);
    @(negedge clk);

    total = checker_i.data_errors + checker_i.proto_errors + checker_i.irq_errors;
    if (checker_i.rsp_count != n_sent) begin
      $display("Response count wrong: %0d requests sent, %0d responses seen",
               n_sent, checker_i.rsp_count);
      total++;
    end
    $display("Errors: data %0d, protocol %0d, interrupt %0d, total %0d",
             checker_i.data_errors, checker_i.proto_errors, checker_i.irq_errors, total);
    if (total == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- user_domain.sv
// User domain top; set the parameters here and connect the core's subordinate bus and GPIOs
`default_nettype none

module user_domain import user_pkg::*; #(
  parameter int unsigned GpioCount       = 16,
  parameter int unsigned NumExternalIrqs = 4,
  parameter int unsigned ScratchDepth    = 64
) (
  input  wire logic                       clk_i,
  input  wire logic                       reset_i,

  // Subordinate port from the core
  input  wire logic                       req_i,
  output logic                            gnt_o,
  input  wire logic [AddrWidth-1:0]       addr_i,
  input  wire logic                       we_i,
  input  wire logic [DataWidth/8-1:0]     be_i,
  input  wire logic [DataWidth-1:0]       wdata_i,
  output logic                            rvalid_o,
  output logic [DataWidth-1:0]            rdata_o,
  output logic                            err_o,

  // Already synchronized pins
  input  wire logic [GpioCount-1:0]       gpio_in_sync_i,
  output logic [NumExternalIrqs-1:0]      interrupts_o
);

  // ------------------------------------------------------------------------
  // Subordinate buses
  // ------------------------------------------------------------------------

  // Scratch memory
  logic                   mem_req, mem_gnt, mem_we, mem_rvalid, mem_err;
  logic [AddrWidth-1:0]   mem_addr;
  logic [DataWidth/8-1:0] mem_be;
  logic [DataWidth-1:0]   mem_wdata, mem_rdata;

  // GPIO unit
  logic                   gpio_req, gpio_gnt, gpio_we, gpio_rvalid, gpio_err;
  logic [AddrWidth-1:0]   gpio_addr;
  logic [DataWidth/8-1:0] gpio_be;
  logic [DataWidth-1:0]   gpio_wdata, gpio_rdata;

  // Error subordinate
  logic                   err_req, err_gnt, err_we, err_rvalid, err_err;
  logic [AddrWidth-1:0]   err_addr;
  logic [DataWidth/8-1:0] err_be;
  logic [DataWidth-1:0]   err_wdata, err_rdata;

  // ------------------------------------------------------------------------
  // Demux and subordinates
  // ------------------------------------------------------------------------

  user_obi_demux i_demux (
    .clk_i, .reset_i,
    .req_i, .gnt_o, .addr_i, .we_i, .be_i, .wdata_i, .rvalid_o, .rdata_o, .err_o,
    .mem_req_o    (mem_req),    .mem_gnt_i    (mem_gnt),    .mem_addr_o   (mem_addr),
    .mem_we_o     (mem_we),     .mem_be_o     (mem_be),     .mem_wdata_o  (mem_wdata),
    .mem_rvalid_i (mem_rvalid), .mem_rdata_i  (mem_rdata),  .mem_err_i    (mem_err),
    .gpio_req_o   (gpio_req),   .gpio_gnt_i   (gpio_gnt),   .gpio_addr_o  (gpio_addr),
    .gpio_we_o    (gpio_we),    .gpio_be_o    (gpio_be),    .gpio_wdata_o (gpio_wdata),
    .gpio_rvalid_i(gpio_rvalid),.gpio_rdata_i (gpio_rdata), .gpio_err_i   (gpio_err),
    .err_req_o    (err_req),    .err_gnt_i    (err_gnt),    .err_addr_o   (err_addr),
    .err_we_o     (err_we),     .err_be_o     (err_be),     .err_wdata_o  (err_wdata),
    .err_rvalid_i (err_rvalid), .err_rdata_i  (err_rdata),  .err_err_i    (err_err)
  );

  user_scratch_mem #(
    .ScratchDepth (ScratchDepth)
  ) i_scratch (
    .clk_i, .reset_i,
    .req_i    (mem_req),    .gnt_o   (mem_gnt),   .addr_i  (mem_addr),
    .we_i     (mem_we),     .be_i    (mem_be),    .wdata_i (mem_wdata),
    .rvalid_o (mem_rvalid), .rdata_o (mem_rdata), .err_o   (mem_err)
  );

  user_gpio_irq #(
    .GpioCount       (GpioCount),
    .NumExternalIrqs (NumExternalIrqs)
  ) i_gpio (
    .clk_i, .reset_i,
    .req_i    (gpio_req),    .gnt_o   (gpio_gnt),   .addr_i  (gpio_addr),
    .we_i     (gpio_we),     .be_i    (gpio_be),    .wdata_i (gpio_wdata),
    .rvalid_o (gpio_rvalid), .rdata_o (gpio_rdata), .err_o   (gpio_err),
    .gpio_i   (gpio_in_sync_i),
    .irq_o    (interrupts_o)
  );

  // Catches everything outside the map
  user_err_sbr i_err (
    .clk_i, .reset_i,
    .req_i    (err_req),    .gnt_o   (err_gnt),   .addr_i  (err_addr),
    .we_i     (err_we),     .be_i    (err_be),    .wdata_i (err_wdata),
    .rvalid_o (err_rvalid), .rdata_o (err_rdata), .err_o   (err_err)
  );

endmodule

`default_nettype wire

//--- user_err_sbr.sv
// Error subordinate for unmapped addresses; completes every access with an error response
`default_nettype none

module user_err_sbr import user_pkg::*; (
  input  wire logic                   clk_i,
  input  wire logic                   reset_i,
  input  wire logic                   req_i,
  output logic                        gnt_o,
  input  wire logic [AddrWidth-1:0]   addr_i,
  input  wire logic                   we_i,
  input  wire logic [DataWidth/8-1:0] be_i,
  input  wire logic [DataWidth-1:0]   wdata_i,
  output logic                        rvalid_o,
  output logic [DataWidth-1:0]        rdata_o,
  output logic                        err_o
);

  logic accept;
  logic rvalid_q;

  // Never stalls the bus
  assign gnt_o  = 1'b1;
  assign accept = req_i && gnt_o;

  // Address, write flag, strobes and write data are taken and dropped
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= accept;
    end
  end

  // ------------------------------------------------------------------------
  // Response
  // ------------------------------------------------------------------------

  assign rvalid_o = rvalid_q;

  // Flag rides with the response only, so err stays low when idle
  assign err_o = rvalid_q;

  // Marker word
  assign rdata_o = ErrRspData;

endmodule

`default_nettype wire

//--- user_gpio_irq.sv
// GPIO edge-interrupt subordinate; enables, sticky W1C status and interrupt lines to the core
`default_nettype none

module user_gpio_irq import user_pkg::*; #(
  // At most 32
  parameter int unsigned GpioCount       = 16,
  parameter int unsigned NumExternalIrqs = 4
) (
  input  wire logic                       clk_i,
  input  wire logic                       reset_i,
  input  wire logic                       req_i,
  output logic                            gnt_o,
  input  wire logic [AddrWidth-1:0]       addr_i,
  input  wire logic                       we_i,
  input  wire logic [DataWidth/8-1:0]     be_i,
  input  wire logic [DataWidth-1:0]       wdata_i,
  output logic                            rvalid_o,
  output logic [DataWidth-1:0]            rdata_o,
  output logic                            err_o,
  input  wire logic [GpioCount-1:0]       gpio_i,
  output logic [NumExternalIrqs-1:0]      irq_o
);

  logic                 accept;
  logic                 in_regs;
  user_gpio_reg_e       reg_sel;
  logic [DataWidth-1:0] wmask;
  logic [GpioCount-1:0] wbits;
  logic [GpioCount-1:0] wkeep;
  logic                 rise_we;
  logic                 fall_we;
  logic [GpioCount-1:0] status_clr;
  logic [GpioCount-1:0] status_set;
  logic [DataWidth-1:0] rdata_d;
  logic [GpioCount-1:0] gpio_q;
  logic [GpioCount-1:0] rise_en_q;
  logic [GpioCount-1:0] fall_en_q;
  logic [GpioCount-1:0] status_q;
  logic                 rvalid_q;
  logic [DataWidth-1:0] rdata_q;

  assign gnt_o  = 1'b1;
  assign accept = req_i && gnt_o;

  // ------------------------------------------------------------------------
  // Register decode
  // ------------------------------------------------------------------------

  // Registers only in the first 16 bytes of the window
  assign in_regs = (addr_i[11:4] == '0);
  assign reg_sel = user_gpio_reg_e'(addr_i[3:0]);

  // Byte enables widened to a bit mask
  always_comb begin
    for (int unsigned b = 0; b < DataWidth / 8; b++) begin
      wmask[8*b +: 8] = {8{be_i[b]}};
    end
  end

  assign wbits = wdata_i[GpioCount-1:0] & wmask[GpioCount-1:0];
  assign wkeep = ~wmask[GpioCount-1:0];

  // Read data and write strobes; GpioIn is read-only, other offsets read zero
  always_comb begin
    rdata_d    = '0;
    rise_we    = 1'b0;
    fall_we    = 1'b0;
    status_clr = '0;
    if (in_regs) begin
      case (reg_sel)
        GpioIn:     rdata_d = DataWidth'(gpio_i);
        GpioRiseEn: begin
          rdata_d = DataWidth'(rise_en_q);
          rise_we = accept && we_i;
        end
        GpioFallEn: begin
          rdata_d = DataWidth'(fall_en_q);
          fall_we = accept && we_i;
        end
        GpioStatus: begin
          rdata_d = DataWidth'(status_q);
          if (accept && we_i) begin
            status_clr = wbits;
          end
        end
        default:    rdata_d = '0;
      endcase
    end
  end

  // ------------------------------------------------------------------------
  // Edge detection and state
  // ------------------------------------------------------------------------

  // Enabled rising or falling edges against last cycle's input
  assign status_set = (gpio_i & ~gpio_q & rise_en_q) | (~gpio_i & gpio_q & fall_en_q);

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      gpio_q    <= '0;
      rise_en_q <= '0;
      fall_en_q <= '0;
      status_q  <= '0;
      rvalid_q  <= 1'b0;
    end else begin
      gpio_q <= gpio_i;
      if (rise_we) begin
        rise_en_q <= (rise_en_q & wkeep) | wbits;
      end
      if (fall_we) begin
        fall_en_q <= (fall_en_q & wkeep) | wbits;
      end
      // New edge beats the clear
      status_q <= (status_q & ~status_clr) | status_set;
      rvalid_q <= accept;
    end
  end

  // Pre-write state goes back to the manager
  always_ff @(posedge clk_i) begin
    if (accept && !we_i) begin
      rdata_q <= rdata_d;
    end
  end

  assign rvalid_o = rvalid_q;
  assign rdata_o  = rdata_q;
  assign err_o    = 1'b0;

  // Line k collects every status bit with index k modulo the line count
  always_comb begin
    irq_o = '0;
    for (int unsigned i = 0; i < GpioCount; i++) begin
      irq_o[i % NumExternalIrqs] = irq_o[i % NumExternalIrqs] | status_q[i];
    end
  end

endmodule

`default_nettype wire

//--- user_obi_demux.sv
// OBI demux; decodes the manager address and routes one request per cycle to a subordinate
`default_nettype none

module user_obi_demux import user_pkg::*; (
  input  wire logic                   clk_i,
  input  wire logic                   reset_i,

  // Manager side
  input  wire logic                   req_i,
  output logic                        gnt_o,
  input  wire logic [AddrWidth-1:0]   addr_i,
  input  wire logic                   we_i,
  input  wire logic [DataWidth/8-1:0] be_i,
  input  wire logic [DataWidth-1:0]   wdata_i,
  output logic                        rvalid_o,
  output logic [DataWidth-1:0]        rdata_o,
  output logic                        err_o,

  // Scratch memory
  output logic                        mem_req_o,
  input  wire logic                   mem_gnt_i,
  output logic [AddrWidth-1:0]        mem_addr_o,
  output logic                        mem_we_o,
  output logic [DataWidth/8-1:0]      mem_be_o,
  output logic [DataWidth-1:0]        mem_wdata_o,
  input  wire logic                   mem_rvalid_i,
  input  wire logic [DataWidth-1:0]   mem_rdata_i,
  input  wire logic                   mem_err_i,

  // GPIO unit
  output logic                        gpio_req_o,
  input  wire logic                   gpio_gnt_i,
  output logic [AddrWidth-1:0]        gpio_addr_o,
  output logic                        gpio_we_o,
  output logic [DataWidth/8-1:0]      gpio_be_o,
  output logic [DataWidth-1:0]        gpio_wdata_o,
  input  wire logic                   gpio_rvalid_i,
  input  wire logic [DataWidth-1:0]   gpio_rdata_i,
  input  wire logic                   gpio_err_i,

  // Error subordinate
  output logic                        err_req_o,
  input  wire logic                   err_gnt_i,
  output logic [AddrWidth-1:0]        err_addr_o,
  output logic                        err_we_o,
  output logic [DataWidth/8-1:0]      err_be_o,
  output logic [DataWidth-1:0]        err_wdata_o,
  input  wire logic                   err_rvalid_i,
  input  wire logic [DataWidth-1:0]   err_rdata_i,
  input  wire logic                   err_err_i
);

  user_target_e sel_target;
  user_target_e rsp_target_q;

  // ------------------------------------------------------------------------
  // Address decode
  // ------------------------------------------------------------------------

  // Anything outside both windows lands on the error subordinate
  always_comb begin
    sel_target = UserError;
    if (addr_i >= ScratchBase && addr_i < ScratchBase + ScratchSize) begin
      sel_target = UserScratch;
    end else if (addr_i >= GpioBase && addr_i < GpioBase + GpioSize) begin
      sel_target = UserGpio;
    end
  end

  // ------------------------------------------------------------------------
  // Request path
  // ------------------------------------------------------------------------

  // Only the selected subordinate sees req
  assign mem_req_o  = req_i && (sel_target == UserScratch);
  assign gpio_req_o = req_i && (sel_target == UserGpio);
  assign err_req_o  = req_i && (sel_target == UserError);

  // Payload fans out unchanged
  assign mem_addr_o   = addr_i;
  assign mem_we_o     = we_i;
  assign mem_be_o     = be_i;
  assign mem_wdata_o  = wdata_i;
  assign gpio_addr_o  = addr_i;
  assign gpio_we_o    = we_i;
  assign gpio_be_o    = be_i;
  assign gpio_wdata_o = wdata_i;
  assign err_addr_o   = addr_i;
  assign err_we_o     = we_i;
  assign err_be_o     = be_i;
  assign err_wdata_o  = wdata_i;

  // Grant of the addressed subordinate, same cycle
  always_comb begin
    case (sel_target)
      UserScratch: gnt_o = mem_gnt_i;
      UserGpio:    gnt_o = gpio_gnt_i;
      default:     gnt_o = err_gnt_i;
    endcase
  end

  // ------------------------------------------------------------------------
  // Response path
  // ------------------------------------------------------------------------

  // Remember who answers next cycle
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rsp_target_q <= UserError;
    end else if (req_i && gnt_o) begin
      rsp_target_q <= sel_target;
    end
  end

  // Steered by the registered target, so the next decode does not disturb it
  always_comb begin
    case (rsp_target_q)
      UserScratch: begin
        rvalid_o = mem_rvalid_i;
        rdata_o  = mem_rdata_i;
        err_o    = mem_err_i;
      end
      UserGpio: begin
        rvalid_o = gpio_rvalid_i;
        rdata_o  = gpio_rdata_i;
        err_o    = gpio_err_i;
      end
      default: begin
        rvalid_o = err_rvalid_i;
        rdata_o  = err_rdata_i;
        err_o    = err_err_i;
      end
    endcase
  end

endmodule

`default_nettype wire

//--- user_pkg.sv
// Shared address map, bus widths and encodings for the user domain; import with user_pkg::*
`default_nettype none

package user_pkg;

  // ------------------------------------------------------------------------
  // Bus widths
  // ------------------------------------------------------------------------

  // Fixed by the core bus
  localparam int unsigned AddrWidth = 32;
  localparam int unsigned DataWidth = 32;

  // ------------------------------------------------------------------------
  // Address map
  // ------------------------------------------------------------------------

  // Start of the user region
  localparam logic [AddrWidth-1:0] UserBaseAddr = 32'h2000_0000;

  // Scratch memory window, first 4 KiB of the region
  localparam logic [AddrWidth-1:0] ScratchBase = UserBaseAddr;
  localparam logic [AddrWidth-1:0] ScratchSize = 32'h0000_1000;

  // GPIO window directly above the scratch memory
  localparam logic [AddrWidth-1:0] GpioBase = 32'h2000_1000;
  localparam logic [AddrWidth-1:0] GpioSize = 32'h0000_1000;

  // Returned on every unmapped access
  localparam logic [DataWidth-1:0] ErrRspData = 32'hBADC_AB1E;

  // ------------------------------------------------------------------------
  // Encodings
  // ------------------------------------------------------------------------

  // Demux targets, error subordinate is the default
  typedef enum logic [1:0] {
    UserError   = 2'd0,
    UserScratch = 2'd1,
    UserGpio    = 2'd2
  } user_target_e;

  // GPIO register word offsets, low address nibble
  typedef enum logic [3:0] {
    GpioIn     = 4'h0,
    GpioRiseEn = 4'h4,
    GpioFallEn = 4'h8,
    GpioStatus = 4'hC
  } user_gpio_reg_e;

endpackage

`default_nettype wire

//--- user_scratch_mem.sv
// Word-addressed scratch memory subordinate; byte-enable writes, reads answered one cycle later
`default_nettype none

module user_scratch_mem import user_pkg::*; #(
  // Words, power of two, at least 2
  parameter int unsigned ScratchDepth = 64
) (
  input  wire logic                   clk_i,
  input  wire logic                   reset_i,
  input  wire logic                   req_i,
  output logic                        gnt_o,
  input  wire logic [AddrWidth-1:0]   addr_i,
  input  wire logic                   we_i,
  input  wire logic [DataWidth/8-1:0] be_i,
  input  wire logic [DataWidth-1:0]   wdata_i,
  output logic                        rvalid_o,
  output logic [DataWidth-1:0]        rdata_o,
  output logic                        err_o
);

  localparam int unsigned IdxWidth = $clog2(ScratchDepth);

  logic [DataWidth-1:0] mem_q [ScratchDepth];
  logic [IdxWidth-1:0]  word_idx;
  logic                 accept;
  logic                 rvalid_q;
  logic [DataWidth-1:0] rdata_q;

  // Always ready
  assign gnt_o  = 1'b1;
  assign accept = req_i && gnt_o;

  // Word bits only, upper bits alias
  assign word_idx = addr_i[IdxWidth+1:2];

  // Byte merge under be_i
  always_ff @(posedge clk_i) begin
    if (accept && we_i) begin
      for (int unsigned b = 0; b < DataWidth / 8; b++) begin
        if (be_i[b]) begin
          mem_q[word_idx][8*b +: 8] <= wdata_i[8*b +: 8];
        end
      end
    end
  end

  // Old word is captured, a same-cycle write shows up only afterwards
  always_ff @(posedge clk_i) begin
    if (accept && !we_i) begin
      rdata_q <= mem_q[word_idx];
    end
  end

  // One response per accepted request
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= accept;
    end
  end

  assign rvalid_o = rvalid_q;
  assign rdata_o  = rdata_q;
  assign err_o    = 1'b0;

endmodule

`default_nettype wire

//--- verilog.f
user_pkg.sv
user_obi_demux.sv
user_scratch_mem.sv
user_gpio_irq.sv
user_err_sbr.sv
user_domain.sv
tb_clock_gen.sv
tb_obi_checker.sv
tb_user_domain.sv
